// ==== include/lc3b_mem_consts.svh ====
`ifndef LC3B_MEM_CONSTS_SVH
`define LC3B_MEM_CONSTS_SVH

// data path and address width of the core
`define LC3B_WORD_W 16

// data memory depth in 16-bit words
// addresses wrap on the word address bits
`define LC3B_MEM_WORDS 256

// cycles from the first request cycle to the response
`define LC3B_MEM_LATENCY 2

`endif

// ==== source/lc3b_isa_pkg.sv ====
`include "lc3b_mem_consts.svh"

package lc3b_isa_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;

    // LC-3b opcode encodings that the memory stage cares about
    // anything else reaches the stage as op_nop
    typedef enum logic [3:0] {
        op_nop  = 4'b0000,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_trap = 4'b1111
    } lc3b_opcode;

    // control bits carried down the pipe with an instruction
    // only the opcode is needed in the memory stage so far
    typedef struct packed {
        lc3b_opcode opcode;
    } lc3b_control_word;

endpackage

// ==== source/lc3b_mem_bus_pkg.sv ====
package lc3b_mem_bus_pkg;

    import lc3b_isa_pkg::*;

    // one decoded operation as handed over from execute
    typedef struct packed {
        lc3b_control_word ctrl;
        lc3b_word         src_data;
        lc3b_word         alu_data;   // effective address
        lc3b_word         trapvect8;  // vector in the low byte with the upper byte zero
    } mem_op_t;

    // data memory request qualified by data_request
    typedef struct packed {
        lc3b_word   address;
        lc3b_word   wdata;
        logic [1:0] byte_enable;  // [0] low byte, [1] high byte
        logic       write;
    } mem_req_t;

    // data memory response qualified by data_response
    typedef struct packed {
        lc3b_word rdata;
    } mem_rsp_t;

endpackage

// ==== source/lc3b_stage_latch.sv ====
`timescale 1ns/1ps

module lc3b_stage_latch
    import lc3b_isa_pkg::*;
    import lc3b_mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     advance,
    input  logic     issue_valid,
    input  mem_op_t  issue,
    input  logic     ready,
    input  logic     load_memaddr,
    input  lc3b_word rdata,
    output logic     issue_ready,
    output logic     op_valid,
    output logic     done,
    output mem_op_t  op
);

    // op leaves the stage when its access is complete and downstream takes it
    assign done = op_valid && ready && advance;

    // empty or emptying this cycle and not flushing
    assign issue_ready = !flush && (!op_valid || done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else if (flush) begin
            op_valid <= 1'b0;
        end else if (issue_ready) begin
            op_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_ready && issue_valid) begin
            op <= issue;
        end else if (load_memaddr) begin
            // indirect pointer becomes the effective address
            op.alu_data <= rdata;
        end
    end

    // pointer fetch only for a held op and never in the cycle a new op is taken
    assert property (@(posedge clk) disable iff (!rst_n)
        load_memaddr |-> op_valid && !issue_ready);

endmodule

// ==== source/lc3b_mem_stage_ctrl.sv ====
`timescale 1ns/1ps

module lc3b_mem_stage_ctrl
    import lc3b_isa_pkg::*;
    import lc3b_mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     advance,
    input  logic     op_valid,
    input  mem_op_t  op,
    input  logic     data_response,
    input  mem_rsp_t rsp,
    output logic     data_request,
    output mem_req_t req,
    output lc3b_word mem_output,
    output logic     ready,
    output logic     load_memaddr
);

    typedef enum logic {
        first_hit,
        second_hit
    } state_t;

    state_t     state;
    state_t     next_state;
    lc3b_opcode opcode;
    logic       is_access;
    logic       need_second;
    logic       final_rsp;
    logic       held;
    lc3b_word   held_data;
    lc3b_word   load_data;

    assign opcode = op.ctrl.opcode;

    assign is_access = opcode inside {op_ldb, op_ldi, op_ldr, op_stb, op_sti, op_str, op_trap};

    // indirect ops read the pointer first
    assign need_second = (opcode == op_ldi) || (opcode == op_sti);

    // last response of the sequence for this op
    assign final_rsp = op_valid && !flush && !held && is_access && data_response &&
                       ((state == second_hit) || !need_second);

    // no further requests once the result waits for advance
    assign data_request = op_valid && is_access && !held && !flush;

    // non-memory ops pass straight through
    assign ready = op_valid && !flush && (held || final_rsp || !is_access);

    // latch swaps the pointer word from rsp in at the next edge
    assign load_memaddr = op_valid && !flush && need_second && (state == first_hit) &&
                          data_response;

    assign mem_output = held ? held_data : load_data;

    always_comb begin : request_fields
        req             = '0;
        req.address     = op.alu_data;
        req.byte_enable = 2'b11;
        case (opcode)
            op_stb: begin
                req.write = 1'b1;
                // byte goes to the lane picked by the low address bit
                if (op.alu_data[0]) begin
                    req.wdata       = {op.src_data[7:0], 8'd0};
                    req.byte_enable = 2'b10;
                end else begin
                    req.wdata       = {8'd0, op.src_data[7:0]};
                    req.byte_enable = 2'b01;
                end
            end
            op_str: begin
                req.write = 1'b1;
                req.wdata = op.src_data;
            end
            op_sti: begin
                // first hit is a plain read of the pointer
                if (state == second_hit) begin
                    req.write = 1'b1;
                    req.wdata = op.src_data;
                end
            end
            op_trap: begin
                // vector table entry at trapvect8 times two
                req.address = {7'd0, op.trapvect8[7:0], 1'b0};
            end
            default: ;
        endcase
    end

    always_comb begin : load_format
        load_data = '0;
        case (opcode)
            op_ldb: begin
                if (op.alu_data[0]) begin
                    load_data = {8'd0, rsp.rdata[15:8]};
                end else begin
                    load_data = {8'd0, rsp.rdata[7:0]};
                end
            end
            op_ldr, op_ldi, op_trap: begin
                load_data = rsp.rdata;
            end
            default: ;
        endcase
    end

    always_comb begin : next_state_logic
        next_state = state;
        case (state)
            first_hit: begin
                if (load_memaddr) begin
                    next_state = second_hit;
                end
            end
            second_hit: begin
                // stay until the downstream stage takes the result
                if (ready && advance) begin
                    next_state = first_hit;
                end
            end
            default: next_state = first_hit;
        endcase
        if (flush) begin
            next_state = first_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= first_hit;
            held  <= 1'b0;
        end else begin
            state <= next_state;
            if (flush || (ready && advance)) begin
                held <= 1'b0;
            end else if (final_rsp) begin
                held <= 1'b1;
            end
        end
    end

    // result kept while advance is low
    always_ff @(posedge clk) begin
        if (final_rsp) begin
            held_data <= load_data;
        end
    end

    // a pending request is only withdrawn by flush
    assert property (@(posedge clk) disable iff (!rst_n || flush)
        data_request && !data_response |=> data_request);

    // address, data and enables may not move before the response
    assert property (@(posedge clk) disable iff (!rst_n || flush)
        data_request && !data_response |=> $stable(req));

endmodule

// ==== source/lc3b_data_mem.sv ====
`timescale 1ns/1ps

`include "lc3b_mem_consts.svh"

module lc3b_data_mem
    import lc3b_isa_pkg::*;
    import lc3b_mem_bus_pkg::*;
#(
    parameter int LATENCY = `LC3B_MEM_LATENCY
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     data_request,
    input  mem_req_t req,
    output logic     data_response,
    output mem_rsp_t rsp
);

    localparam int IDX_W = $clog2(`LC3B_MEM_WORDS);
    localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

    lc3b_word         mem [`LC3B_MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [CNT_W-1:0] cnt;
    logic             rsp_due;

    // word address since bit 0 only selects the byte lane
    assign idx = req.address[IDX_W:1];

    // the response goes out LATENCY cycles after the first request cycle
    assign rsp_due = data_request && !data_response && (cnt == CNT_W'(LATENCY - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt           <= '0;
            data_response <= 1'b0;
        end else begin
            data_response <= rsp_due;
            if (data_request && !data_response && !rsp_due) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
            end
        end
    end

    // read on the way into the response cycle
    always_ff @(posedge clk) begin
        if (rsp_due) begin
            rsp.rdata <= mem[idx];
        end
    end

    // writes land at the end of the response cycle
    always_ff @(posedge clk) begin
        if (data_response && data_request && req.write) begin
            if (req.byte_enable[0]) begin
                mem[idx][7:0] <= req.wdata[7:0];
            end
            if (req.byte_enable[1]) begin
                mem[idx][15:8] <= req.wdata[15:8];
            end
        end
    end

endmodule

// ==== source/lc3b_mem_stage_top.sv ====
`timescale 1ns/1ps

module lc3b_mem_stage_top
    import lc3b_isa_pkg::*;
    import lc3b_mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     advance,
    input  logic     issue_valid,
    input  mem_op_t  issue,
    output logic     issue_ready,
    output logic     done,
    output lc3b_word mem_output
);

    logic     op_valid;
    mem_op_t  op;
    logic     ready;
    logic     load_memaddr;
    logic     data_request;
    logic     data_response;
    mem_req_t req;
    mem_rsp_t rsp;

    lc3b_stage_latch u_latch (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .advance      (advance),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .ready        (ready),
        .load_memaddr (load_memaddr),
        .rdata        (rsp.rdata),
        .issue_ready  (issue_ready),
        .op_valid     (op_valid),
        .done         (done),
        .op           (op)
    );

    lc3b_mem_stage_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .advance       (advance),
        .op_valid      (op_valid),
        .op            (op),
        .data_response (data_response),
        .rsp           (rsp),
        .data_request  (data_request),
        .req           (req),
        .mem_output    (mem_output),
        .ready         (ready),
        .load_memaddr  (load_memaddr)
    );

    lc3b_data_mem u_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .data_request  (data_request),
        .req           (req),
        .data_response (data_response),
        .rsp           (rsp)
    );

endmodule

// ==== sim/tb_lc3b_mem_stage.sv ====
`timescale 1ns/1ps

`include "lc3b_mem_consts.svh"

module tb_lc3b_mem_stage
    import lc3b_isa_pkg::*;
    import lc3b_mem_bus_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 64;

    // one table row with the op and its check and flush flags
    typedef struct packed {
        mem_op_t op;
        logic    check_out;
        logic    flush_it;
    } entry_t;

    logic     clk;
    logic     rst_n;
    logic     flush;
    logic     advance;
    logic     issue_valid;
    mem_op_t  issue;
    logic     issue_ready;
    logic     done;
    lc3b_word mem_output;

    integer   seed;
    int       errors;
    int       timeouts;
    int       done_seen;
    int       done_expected;
    entry_t   stim [$];
    lc3b_word shadow [`LC3B_MEM_WORDS];

    lc3b_mem_stage_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .advance     (advance),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .done        (done),
        .mem_output  (mem_output)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // count every completion pulse
    always @(negedge clk) begin
        if (rst_n && done) begin
            done_seen = done_seen + 1;
        end
    end

    function automatic int word_index(lc3b_word addr);
        return (int'(addr) / 2) % `LC3B_MEM_WORDS;
    endfunction

    task automatic add_entry(input lc3b_opcode opc, input lc3b_word src, input lc3b_word addr,
                             input logic [7:0] vect, input logic check_out, input logic flush_it);
        entry_t e;
        e                   = '0;
        e.op.ctrl.opcode    = opc;
        e.op.src_data       = src;
        e.op.alu_data       = addr;
        e.op.trapvect8      = {8'd0, vect};
        e.check_out         = check_out;
        e.flush_it          = flush_it;
        stim.push_back(e);
    endtask

    // shadow memory update and expected load value
    task automatic predict(input mem_op_t o, output lc3b_word expect_out);
        int w;
        int p;
        expect_out = '0;
        w = word_index(o.alu_data);
        case (o.ctrl.opcode)
            op_str: begin
                shadow[w] = o.src_data;
            end
            op_stb: begin
                if (o.alu_data[0]) begin
                    shadow[w][15:8] = o.src_data[7:0];
                end else begin
                    shadow[w][7:0] = o.src_data[7:0];
                end
            end
            op_ldr: begin
                expect_out = shadow[w];
            end
            op_ldb: begin
                expect_out = o.alu_data[0] ? {8'h00, shadow[w][15:8]} : {8'h00, shadow[w][7:0]};
            end
            op_ldi: begin
                p = word_index(shadow[w]);
                expect_out = shadow[p];
            end
            op_sti: begin
                p = word_index(shadow[w]);
                shadow[p] = o.src_data;
            end
            op_trap: begin
                expect_out = shadow[word_index(lc3b_word'(o.trapvect8[7:0]) * 2)];
            end
            default: ;
        endcase
    endtask

    task automatic check_word(input lc3b_word got, input lc3b_word expected, input int entry);
        if (got !== expected) begin
            errors++;
            $display("[FAIL] t=%0t entry %0d: mem_output %h, expected %h",
                     $time, entry, got, expected);
        end
    endtask

    task automatic check_op_done(input mem_op_t op, input int expected, input int seen);
        if (seen !== expected) begin
            errors++;
            $display("[FAIL] t=%0t after opcode %h: %0d done pulses, expected %0d",
                     $time, op.ctrl.opcode, seen, expected);
        end
    endtask

    // step to the drive point of the next cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        advance = ({$random(seed)} % 4) != 0;
    endtask

    task automatic wait_issue(output bit timed_out);
        int n;
        n = 0;
        timed_out = 1'b0;
        @(negedge clk);
        while (!issue_ready && !timed_out) begin
            next_cycle();
            @(negedge clk);
            n++;
            timed_out = (n >= TIMEOUT_CYCLES);
        end
    endtask

    task automatic wait_done(output bit timed_out, output lc3b_word got);
        int n;
        n = 0;
        timed_out = 1'b0;
        @(negedge clk);
        while (!done && !timed_out) begin
            next_cycle();
            @(negedge clk);
            n++;
            timed_out = (n >= TIMEOUT_CYCLES);
        end
        got = mem_output;
    endtask

    task automatic run_entry(input int i, output bit timed_out);
        lc3b_word expect_out;
        lc3b_word got;
        issue       = stim[i].op;
        issue_valid = 1'b1;
        wait_issue(timed_out);
        if (timed_out) begin
            timeouts++;
            $display("timeout: entry %0d was never accepted by the stage", i);
            return;
        end
        next_cycle();
        issue_valid = 1'b0;
        if (stim[i].flush_it) begin
            // kill the store in its response cycle before the write lands
            repeat (`LC3B_MEM_LATENCY) begin
                next_cycle();
            end
            flush = 1'b1;
            next_cycle();
            flush = 1'b0;
            wait_issue(timed_out);
            if (timed_out) begin
                timeouts++;
                $display("timeout: issue_ready never came back after the flush of entry %0d", i);
                return;
            end
            next_cycle();
            check_op_done(stim[i].op, done_expected, done_seen);
            return;
        end
        predict(stim[i].op, expect_out);
        done_expected++;
        wait_done(timed_out, got);
        if (timed_out) begin
            timeouts++;
            $display("timeout: entry %0d never signalled done", i);
            return;
        end
        if (stim[i].check_out) begin
            check_word(got, expect_out, i);
        end
        next_cycle();
        check_op_done(stim[i].op, done_expected, done_seen);
    endtask

    task automatic fill_table();
        add_entry(op_str, 16'h1234, 16'h0010, 8'h00, 1'b0, 1'b0);
        add_entry(op_ldr, 16'h0000, 16'h0010, 8'h00, 1'b1, 1'b0);
        add_entry(op_str, 16'hA5C3, 16'h0020, 8'h00, 1'b0, 1'b0);
        add_entry(op_stb, 16'hFF7E, 16'h0020, 8'h00, 1'b0, 1'b0);
        add_entry(op_stb, 16'h0091, 16'h0021, 8'h00, 1'b0, 1'b0);
        add_entry(op_ldr, 16'h0000, 16'h0020, 8'h00, 1'b1, 1'b0);
        add_entry(op_ldb, 16'h0000, 16'h0020, 8'h00, 1'b1, 1'b0);
        add_entry(op_ldb, 16'h0000, 16'h0021, 8'h00, 1'b1, 1'b0);
        // pointers for the indirect pair
        add_entry(op_str, 16'h0060, 16'h0040, 8'h00, 1'b0, 1'b0);
        add_entry(op_str, 16'hBEEF, 16'h0060, 8'h00, 1'b0, 1'b0);
        add_entry(op_ldi, 16'h0000, 16'h0040, 8'h00, 1'b1, 1'b0);
        add_entry(op_str, 16'h0080, 16'h0042, 8'h00, 1'b0, 1'b0);
        add_entry(op_str, 16'h0000, 16'h0080, 8'h00, 1'b0, 1'b0);
        add_entry(op_sti, 16'hC0DE, 16'h0042, 8'h00, 1'b0, 1'b0);
        add_entry(op_ldr, 16'h0000, 16'h0080, 8'h00, 1'b1, 1'b0);
        // vector table entry 0x1b
        add_entry(op_str, 16'h7777, 16'h0036, 8'h00, 1'b0, 1'b0);
        add_entry(op_trap, 16'h0000, 16'h0000, 8'h1B, 1'b1, 1'b0);
        add_entry(op_str, 16'hDEAD, 16'h0010, 8'h00, 1'b0, 1'b1);
        add_entry(op_ldr, 16'h0000, 16'h0010, 8'h00, 1'b1, 1'b0);
        add_entry(op_ldr, 16'h0000, 16'h0060, 8'h00, 1'b1, 1'b0);
    endtask

    initial begin
        bit timed_out;
        int i;
        seed          = 76;
        errors        = 0;
        timeouts      = 0;
        done_seen     = 0;
        done_expected = 0;
        rst_n         = 1'b0;
        flush         = 1'b0;
        advance       = 1'b0;
        issue_valid   = 1'b0;
        issue         = '0;
        timed_out     = 1'b0;
        fill_table();
        repeat (4) @(posedge clk);
        #1;
        rst_n   = 1'b1;
        advance = 1'b1;
        for (i = 0; i < stim.size() && !timed_out; i++) begin
            run_entry(i, timed_out);
        end
        if (!timed_out) begin
            // no stray completions once the table is drained
            next_cycle();
            next_cycle();
            check_op_done(stim[stim.size() - 1].op, done_expected, done_seen);
        end
        $display("value errors: %0d, timeouts: %0d, done pulses: %0d of %0d",
                 errors, timeouts, done_seen, done_expected);
        if (errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
source/lc3b_isa_pkg.sv
source/lc3b_mem_bus_pkg.sv
source/lc3b_stage_latch.sv
source/lc3b_mem_stage_ctrl.sv
source/lc3b_data_mem.sv
source/lc3b_mem_stage_top.sv
sim/tb_lc3b_mem_stage.sv

// ==== Bender.yml ====
package:
  name: lc3b_mem_stage

sources:
  - include_dirs:
      - include
    files:
      - source/lc3b_isa_pkg.sv
      - source/lc3b_mem_bus_pkg.sv
      - source/lc3b_stage_latch.sv
      - source/lc3b_mem_stage_ctrl.sv
      - source/lc3b_data_mem.sv
      - source/lc3b_mem_stage_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_lc3b_mem_stage.sv
